/* run_sim.sh */
#!/bin/sh
# Compile and run the cpu_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_bus_tb -f vlog.f -o sim_cpu_bus; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_cpu_bus 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* source/bus_deserializer.sv */
/*
 * Read deserializer: gathers the four read bytes of a frame into a word
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module bus_deserializer (
  input  logic                clk,
  input  logic                rst,
  input  bus_pkg::bus_phase_t phase,
  input  bus_pkg::pin_byte_t  bus_data_rd,
  output cpu_pkg::word_t      read_word
);
  import bus_pkg::*;

  logic       sample;
  byte_slot_t slot;

  assign sample = (phase >= bus_phase_t'(`BUS_PHASE_RD_FIRST)) &&
                  (phase <  bus_phase_t'(`BUS_PHASE_RD_FIRST + 4));
  assign slot   = byte_slot_t'(phase - bus_phase_t'(`BUS_PHASE_RD_FIRST));   // LSB first

  always_ff @(posedge clk) begin
    if (rst) begin
      read_word <= '0;
    end else if (sample) begin
      read_word[{slot, 3'b000} +: 8] <= bus_data_rd;
    end
  end

endmodule : bus_deserializer

`default_nettype wire

/* source/bus_pkg.sv */
/*
 * Bus package: pin byte, frame phase and byte lane types
 */
`default_nettype none

package bus_pkg;

  // One byte as it appears on the narrow pins
  typedef logic [7:0] pin_byte_t;

  // Phase number inside a frame
  typedef logic [3:0] bus_phase_t;

  // Byte lane inside a 32-bit word, 0 is least significant
  typedef logic [1:0] byte_slot_t;

endpackage : bus_pkg

`default_nettype wire

/* source/bus_sequencer.sv */
/*
 * Frame sequencer: counts bus phases, steps the processor once per frame
 * and marks each frame start with a sync pulse
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module bus_sequencer (
  input  logic                clk,
  input  logic                rst,
  output bus_pkg::bus_phase_t phase,
  output logic                cpu_step,
  output logic                frame_sync
);
  import bus_pkg::*;

  logic last_phase;

  assign last_phase = (phase == bus_phase_t'(`BUS_FRAME_LEN - 1));
  assign cpu_step   = (phase == '0);   // Processor advances in phase 0

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= '0;
      frame_sync <= 1'b0;
    end else begin
      if (last_phase) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
      frame_sync <= cpu_step;            // High while address byte 0 is out
    end
  end

endmodule : bus_sequencer

`default_nettype wire

/* source/bus_serializer.sv */
/*
 * Pin serializer: puts address, write-data and control bytes on the
 * 8-bit pins, one byte per frame phase
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module bus_serializer (
  input  logic                clk,
  input  logic                rst,
  input  bus_pkg::bus_phase_t phase,
  input  cpu_pkg::addr_t      bus_address,
  input  cpu_pkg::word_t      write_data,
  input  logic                write_en,
  output bus_pkg::pin_byte_t  bus_addr,
  output bus_pkg::pin_byte_t  bus_data_wr,
  output bus_pkg::pin_byte_t  bus_data_oe
);
  import bus_pkg::*;

  bus_phase_t phase_nxt;
  byte_slot_t lane;        // Byte lane shown during this cycle
  logic       word_slot;   // Phases 1 to 4
  logic       ctrl_slot;

  // The pins show the byte of the phase the counter holds in that cycle
  assign phase_nxt = (phase == bus_phase_t'(`BUS_FRAME_LEN - 1)) ? '0 : phase + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      lane      <= '0;
      word_slot <= 1'b0;
      ctrl_slot <= 1'b0;
    end else begin
      lane      <= byte_slot_t'(phase_nxt - 1'b1);
      word_slot <= (phase_nxt != '0) && (phase_nxt < bus_phase_t'(`BUS_PHASE_CTRL));
      ctrl_slot <= (phase_nxt == bus_phase_t'(`BUS_PHASE_CTRL));
    end
  end

  // Core outputs are stable for the frame, only the lane steps
  assign bus_addr    = word_slot ? bus_address[{lane, 3'b000} +: 8]
                     : ctrl_slot ? pin_byte_t'(write_en)
                     : '0;
  assign bus_data_wr = (word_slot && write_en) ? write_data[{lane, 3'b000} +: 8] : '0;
  assign bus_data_oe = {8{word_slot & write_en}};   // Drive only write-data bytes

endmodule : bus_serializer

`default_nettype wire

/* source/cpu_bus_defines.svh */
/*
 * Bus frame timing and processor reset constants
 */
`ifndef CPU_BUS_DEFINES_SVH
`define CPU_BUS_DEFINES_SVH

// One bus transaction per frame
`define BUS_FRAME_LEN      10
`define BUS_PHASE_CTRL     5   // Control byte with the write flag
`define BUS_PHASE_RD_FIRST 6   // Read bytes sampled from here to the frame end

// First fetch address after reset
`define CPU_RESET_PC       0

`endif

/* source/cpu_bus_top.sv */
/*
 * Processor with its memory bus serialized over 8-bit pins
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_top (
  input  logic               clk,
  input  logic               rst,
  input  bus_pkg::pin_byte_t bus_data_rd,
  output bus_pkg::pin_byte_t bus_addr,
  output bus_pkg::pin_byte_t bus_data_wr,
  output bus_pkg::pin_byte_t bus_data_oe,
  output logic               frame_sync
);
  import bus_pkg::*;
  import cpu_pkg::*;

  bus_phase_t phase;
  logic       cpu_step;
  addr_t      bus_address;
  word_t      write_data;
  logic       write_en;
  word_t      read_word;   // Previous frame's read data

  bus_sequencer u_sequencer (
    .clk        (clk),
    .rst        (rst),
    .phase      (phase),
    .cpu_step   (cpu_step),
    .frame_sync (frame_sync)
  );

  cpu_core u_core (
    .clk         (clk),
    .rst         (rst),
    .cpu_step    (cpu_step),
    .read_word   (read_word),
    .bus_address (bus_address),
    .write_data  (write_data),
    .write_en    (write_en)
  );

  bus_serializer u_serializer (
    .clk         (clk),
    .rst         (rst),
    .phase       (phase),
    .bus_address (bus_address),
    .write_data  (write_data),
    .write_en    (write_en),
    .bus_addr    (bus_addr),
    .bus_data_wr (bus_data_wr),
    .bus_data_oe (bus_data_oe)
  );

  bus_deserializer u_deserializer (
    .clk         (clk),
    .rst         (rst),
    .phase       (phase),
    .bus_data_rd (bus_data_rd),
    .read_word   (read_word)
  );

endmodule : cpu_bus_top

`default_nettype wire

/* source/cpu_core.sv */
/*
 * Accumulator processor: one fetch, load or store per bus frame,
 * advancing only on the frame step strobe
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module cpu_core (
  input  logic           clk,
  input  logic           rst,
  input  logic           cpu_step,
  input  cpu_pkg::word_t read_word,
  output cpu_pkg::addr_t bus_address,
  output cpu_pkg::word_t write_data,
  output logic           write_en
);
  import cpu_pkg::*;

  core_state_t state;
  core_state_t state_nxt;
  addr_t       pc;
  addr_t       pc_nxt;
  addr_t       pc_inc;
  addr_t       addr_nxt;
  word_t       acc;
  word_t       acc_nxt;
  logic        we_nxt;
  logic        add_pending;   // Operand read feeds an add
  opcode_t     opcode;
  addr_t       operand;

  assign opcode  = opcode_t'(read_word[31:28]);
  assign operand = {4'b0000, read_word[27:0]};
  assign pc_inc  = pc + 1'b1;

  always_comb begin
    state_nxt = st_fetch;   // Every other path ends in a fetch
    pc_nxt    = pc;
    addr_nxt  = pc;
    we_nxt    = 1'b0;
    acc_nxt   = acc;
    case (state)
      st_fetch: begin
        pc_nxt   = pc_inc;
        addr_nxt = pc_inc;
        case (opcode)
          op_load, op_add: begin
            state_nxt = st_load;
            addr_nxt  = operand;
          end
          op_store: begin
            state_nxt = st_store;
            addr_nxt  = operand;
            we_nxt    = 1'b1;
          end
          op_jump: begin
            pc_nxt   = operand;
            addr_nxt = operand;
          end
          op_jz: begin
            if (acc == '0) begin
              pc_nxt   = operand;
              addr_nxt = operand;
            end
          end
          default: ;   // Undefined codes run as nop
        endcase
      end
      st_load: acc_nxt = add_pending ? acc + read_word : read_word;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_start;
      pc       <= `CPU_RESET_PC;
      acc      <= '0;
      write_en <= 1'b0;
    end else if (cpu_step) begin
      state    <= state_nxt;
      pc       <= pc_nxt;
      acc      <= acc_nxt;
      write_en <= we_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_step) begin
      bus_address <= addr_nxt;
      write_data  <= acc;   // Only driven out in store frames
      if (state == st_fetch) begin
        add_pending <= (opcode == op_add);
      end
    end
  end

endmodule : cpu_core

`default_nettype wire

/* source/cpu_pkg.sv */
/*
 * Processor package: word types, instruction opcodes and core states
 */
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;   // Word address

  // Instruction bits 31 to 28, the operand sits in bits 27 to 0
  typedef enum logic [3:0] {
    op_nop   = 4'h0,
    op_load  = 4'h1,   // acc takes mem[operand]
    op_add   = 4'h2,   // acc takes acc plus mem[operand]
    op_store = 4'h3,   // mem[operand] takes acc
    op_jump  = 4'h4,
    op_jz    = 4'h5    // Branch when acc is zero
  } opcode_t;

  // What the bus frame in flight is doing
  typedef enum logic [1:0] {
    st_start = 2'd0,   // No fetch issued yet
    st_fetch = 2'd1,   // Instruction read
    st_load  = 2'd2,   // Operand read
    st_store = 2'd3    // Operand write
  } core_state_t;

endpackage : cpu_pkg

`default_nettype wire

/* testbench/cpu_bus_asserts.sv */
/*
 * Bus protocol assertions: frame spacing and data enable rules
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module cpu_bus_asserts (
  input logic                clk,
  input logic                rst,
  input bus_pkg::bus_phase_t phase,
  input logic                write_en,
  input bus_pkg::pin_byte_t  bus_data_oe,
  input logic                frame_sync
);

  logic [3:0] since_sync;   // Cycles since the last sync pulse
  logic       seen_sync;

  always_ff @(posedge clk) begin
    if (rst) begin
      since_sync <= '0;
      seen_sync  <= 1'b0;
    end else if (frame_sync) begin
      since_sync <= 4'd1;
      seen_sync  <= 1'b1;
    end else if (since_sync != 4'hf) begin
      since_sync <= since_sync + 4'd1;
    end
  end

  // Next pulse exactly one frame after the previous one
  sync_period: assert property (@(posedge clk) disable iff (rst)
    seen_sync |-> (frame_sync == (since_sync == 4'(`BUS_FRAME_LEN))))
    else $error("frame_sync spacing differs from one frame");

  // Pins show write-data bytes while phase holds 1 to 4
  oe_in_write_slot: assert property (@(posedge clk) disable iff (rst)
    (bus_data_oe != '0) |-> (write_en && phase >= 4'd1 && phase < 4'(`BUS_PHASE_CTRL)))
    else $error("bus_data_oe active outside the write-data cycles");

  // With the rule above the enable bits never disagree
  oe_full_in_write_slot: assert property (@(posedge clk) disable iff (rst)
    (write_en && phase >= 4'd1 && phase < 4'(`BUS_PHASE_CTRL)) |-> (bus_data_oe == '1))
    else $error("bus_data_oe not fully on in a write-data cycle");

endmodule : cpu_bus_asserts

bind cpu_bus_top cpu_bus_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .phase       (phase),
  .write_en    (write_en),
  .bus_data_oe (bus_data_oe),
  .frame_sync  (frame_sync)
);

`default_nettype wire

/* testbench/cpu_bus_tb.sv */
/*
 * Testbench for the serialized-bus processor: random program memory,
 * reference ISA model and pin-level frame checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_bus_defines.svh"

module cpu_bus_tb;
  import bus_pkg::*;
  import cpu_pkg::*;

  localparam int NUM_FRAMES   = 300;
  localparam int SYNC_TIMEOUT = 20;

  logic        clk;
  logic        rst;
  pin_byte_t   bus_data_rd;
  pin_byte_t   bus_addr;
  pin_byte_t   bus_data_wr;
  pin_byte_t   bus_data_oe;
  logic        frame_sync;

  word_t       mem [64];
  logic [31:0] lcg_state;
  int unsigned cycle_cnt = 0;
  int unsigned last_sync;

  // Reference model and the transaction it predicts for the next frame
  core_state_t m_state;
  addr_t       m_pc;
  word_t       m_acc;
  logic        m_add;
  addr_t       exp_addr;
  logic        exp_we;
  word_t       exp_wdata;
  word_t       last_rdata;   // Read data of the frame before
  int          n_store;
  int          n_branch;

  cpu_bus_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .bus_data_rd (bus_data_rd),
    .bus_addr    (bus_addr),
    .bus_data_wr (bus_data_wr),
    .bus_data_oe (bus_data_oe),
    .frame_sync  (frame_sync)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;
  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string tname, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else fail_run($sformatf("error: %s expected %08h actual %08h", tname, expected, actual));
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_frame_sync();
    int waited;
    waited = 0;
    step_cycle();
    while (!frame_sync) begin
      check_value("oe_between_frames", 32'h0, 32'(bus_data_oe));
      waited++;
      if (waited >= SYNC_TIMEOUT) fail_run("timeout: frame_sync did not arrive in 20 cycles");
      step_cycle();
    end
  endtask

  task automatic fill_memory();
    logic [31:0] r;
    logic [3:0]  op;
    for (int i = 0; i < 64; i++) begin
      r = lcg_next();
      case (r[19:16])   // Weighted opcode mix
        4'd0, 4'd1:             op = op_nop;
        4'd2, 4'd3, 4'd4, 4'd5: op = op_load;
        4'd6, 4'd7, 4'd8:       op = op_add;
        4'd9, 4'd10, 4'd11:     op = op_store;
        4'd12:                  op = op_jump;
        4'd13:                  op = op_jz;
        default:                op = 4'(6 + r[23:20] % 10);   // Undefined code
      endcase
      mem[i] = {op, 22'h0, r[31:26]};
    end
  endtask

  // ISA rules: one bus transaction per step
  task automatic model_step(input word_t rdata);
    logic [3:0] op;
    addr_t      operand;
    op        = rdata[31:28];
    operand   = {4'h0, rdata[27:0]};
    exp_we    = 1'b0;
    exp_wdata = '0;
    if (m_state == st_fetch) begin
      m_state = st_fetch;
      if (op == op_load || op == op_add) begin
        m_add   = (op == op_add);
        m_state = st_load;
      end else if (op == op_store) begin
        exp_we    = 1'b1;
        exp_wdata = m_acc;
        m_state   = st_store;
        n_store++;
      end
      if (op == op_jump || (op == op_jz && m_acc == '0)) begin
        m_pc = operand;
        n_branch++;
      end else begin
        m_pc = m_pc + 32'd1;
      end
      exp_addr = (m_state == st_fetch) ? m_pc : operand;
    end else begin
      if (m_state == st_load) m_acc = m_add ? m_acc + rdata : rdata;
      m_state  = st_fetch;
      exp_addr = m_pc;
    end
  endtask

  task automatic run_frame(input int idx);
    word_t     addr_seen;
    word_t     data_seen;
    word_t     rd_word;
    pin_byte_t ctrl;
    wait_frame_sync();
    if (idx > 0) check_value("sync_period", `BUS_FRAME_LEN, cycle_cnt - last_sync);
    last_sync = cycle_cnt;
    model_step(last_rdata);
    for (int k = 0; k < 4; k++) begin
      if (k > 0) step_cycle();
      addr_seen[8*k +: 8] = bus_addr;
      data_seen[8*k +: 8] = bus_data_wr;
      check_value("oe_word_phase", exp_we ? 32'hff : 32'h0, 32'(bus_data_oe));
    end
    step_cycle();
    ctrl = bus_addr;
    check_value("oe_ctrl_phase", 32'h0, 32'(bus_data_oe));
    check_value("address", exp_addr, addr_seen);
    check_value("ctrl_byte", 32'(exp_we), 32'(ctrl));
    if (ctrl[0]) begin
      check_value("store_data", exp_wdata, data_seen);
      mem[addr_seen[5:0]] = data_seen;
      rd_word = lcg_next();   // Nobody drives the pins, so junk
    end else begin
      rd_word = mem[addr_seen[5:0]];
    end
    for (int j = 0; j < 4; j++) begin
      step_cycle();
      bus_data_rd = rd_word[8*j +: 8];
      check_value("idle_pins", 32'h0, {8'h0, bus_addr, bus_data_wr, bus_data_oe});
    end
    last_rdata = rd_word;
  endtask

  initial begin
    rst         = 1'b1;
    bus_data_rd = '0;
    lcg_state   = 32'd8310;
    n_store     = 0;
    n_branch    = 0;
    fill_memory();
    m_state    = st_start;
    m_pc       = `CPU_RESET_PC;
    m_acc      = '0;
    m_add      = 1'b0;
    last_rdata = '0;
    repeat (10) begin
      step_cycle();
      check_value("reset_pins", 32'h0, {bus_addr, bus_data_wr, bus_data_oe, 7'h0, frame_sync});
    end
    rst = 1'b0;
    for (int i = 0; i < NUM_FRAMES; i++) begin
      run_frame(i);
    end
    $display("Store frames %0d, taken branches %0d", n_store, n_branch);
    $display("Test completed successfully");
    $finish;
  end

endmodule : cpu_bus_tb

`default_nettype wire

/* vlog.f */
+incdir+source
source/bus_pkg.sv
source/cpu_pkg.sv
source/bus_sequencer.sv
source/bus_serializer.sv
source/bus_deserializer.sv
source/cpu_core.sv
source/cpu_bus_top.sv
testbench/cpu_bus_asserts.sv
testbench/cpu_bus_tb.sv
